//--- hdl/fdc_pkg.sv
// fdc shared definitions: command opcodes, busy states, drive status and register maps
package fdc_pkg;

  // busy state machine of the register block
  typedef enum logic [1:0] {
    ST_IDLE        = 2'd0,  // no command running
    ST_IRQ_PENDING = 2'd1,  // last busy cycle, irq follows
    ST_INT_WAIT    = 2'd2,  // internal step/seek delay
    ST_IO_WAIT     = 2'd3   // waiting for the io processor dma
  } busy_state_e;

  // one drive mechanism as seen by the controller
  typedef struct packed {
    logic motor_on;  // motor timer running
    logic spun_up;   // past the spin-up phase
    logic index;     // index hole under the sensor
    logic wr_prot;   // write-protect tab
  } drive_status_t;

  // cpu register addresses
  typedef enum logic [1:0] {
    ADDR_CMD    = 2'd0,  // command on write, status on read
    ADDR_TRACK  = 2'd1,
    ADDR_SECTOR = 2'd2,
    ADDR_DATA   = 2'd3
  } reg_addr_e;

  // io processor status byte select codes
  typedef enum logic [2:0] {
    IO_CMD    = 3'd0,
    IO_TRACK  = 3'd1,
    IO_SECTOR = 3'd2,
    IO_DATA   = 3'd3,
    IO_DRIVE  = 3'd4   // drive select, side, io_wait flag
  } io_status_sel_e;

  // type I, matched on cmd[7:4]
  localparam logic [3:0] CMD_RESTORE = 4'b0000;
  localparam logic [3:0] CMD_SEEK    = 4'b0001;

  // type I steps, matched on cmd[7:5], bit 4 is the update flag
  localparam logic [2:0] CMD_STEP     = 3'b001;
  localparam logic [2:0] CMD_STEP_IN  = 3'b010;
  localparam logic [2:0] CMD_STEP_OUT = 3'b011;

  // type II, matched on cmd[7:5]
  localparam logic [2:0] CMD_RD_SECTOR = 3'b100;
  localparam logic [2:0] CMD_WR_SECTOR = 3'b101;

  // type III and IV, matched on cmd[7:4]
  localparam logic [3:0] CMD_RD_ADDR   = 4'b1100;
  localparam logic [3:0] CMD_FORCE_INT = 4'b1101;  // cmd[3:0] is the condition field
  localparam logic [3:0] CMD_RD_TRACK  = 4'b1110;
  localparam logic [3:0] CMD_WR_TRACK  = 4'b1111;

endpackage

//--- hdl/fdc_regs.sv
// fdc register block: cpu registers, command decode, busy/irq fsm and io status byte
`timescale 1ns/10ps

module fdc_regs #(
  parameter int NUM_DRIVES = 2,
  parameter int SEEK_DELAY = 200000,
  parameter int STEP_DELAY = 20000
) (
  input  logic                           clk,
  input  logic                           motor_start,  // async reset
  input  logic                           cpu_sel,
  input  logic                           cpu_rw,       // 1 read, 0 write
  input  fdc_pkg::reg_addr_e             cpu_addr,
  input  logic                     [7:0] cpu_din,
  output logic                     [7:0] cpu_dout,
  output logic                           irq,
  input  logic                     [1:0] drv_sel,
  input  logic                           drv_side,
  input  logic                           dma_ack,
  input  fdc_pkg::io_status_sel_e        status_sel,
  output logic                     [7:0] status_byte,
  input  fdc_pkg::drive_status_t         sel_status,
  output logic          [NUM_DRIVES-1:0] spin_request
);

  // delay counter sized for the longer of the two step delays
  localparam int DLY_MAX = (SEEK_DELAY > STEP_DELAY) ? SEEK_DELAY : STEP_DELAY;
  localparam int DLY_W   = (DLY_MAX < 2) ? 1 : $clog2(DLY_MAX + 1);

  logic [7:0] cmd;     // write only from the cpu side
  logic [7:0] track;
  logic [7:0] sector;
  logic [7:0] data;

  fdc_pkg::busy_state_e state;
  logic                 step_dir;  // 1 = in, towards higher tracks
  logic [DLY_W-1:0]     delay;

  logic                  busy;
  logic                  cmd_type_1;
  logic                  cpu_wr;
  logic                  starts_motor;
  logic [NUM_DRIVES-1:0] sel_vec;     // drv_sel widened to the drive count
  logic [NUM_DRIVES-1:0] req_onehot;  // lowest selected drive only
  logic [7:0]            fdc_status;

  assign busy         = (state != fdc_pkg::ST_IDLE);
  assign cmd_type_1   = (cmd[7] == 1'b0);
  assign cpu_wr       = cpu_sel && !cpu_rw;
  assign starts_motor = (cpu_din[7] == 1'b0) || (cpu_din[7:6] == 2'b10);  // type I and II

  // only two select lines exist, further drives are never addressed
  for (genvar g = 0; g < NUM_DRIVES; g++) begin : g_sel
    if (g < 2) begin : g_line
      assign sel_vec[g] = drv_sel[g];
    end else begin : g_none
      assign sel_vec[g] = 1'b0;
    end
  end

  assign req_onehot = sel_vec & (~sel_vec + NUM_DRIVES'(1));  // isolate lowest set bit

  // status register as the cpu reads it at address 0
  assign fdc_status = {
    sel_status.motor_on,
    sel_status.wr_prot,
    cmd_type_1 ? sel_status.spun_up : 1'b0,
    2'b00,                                     // no record-not-found, no crc error
    cmd_type_1 ? (track == 8'd0) : 1'b0,       // track 0
    cmd_type_1 ? sel_status.index : busy,      // index or drq
    busy
  };

  always_comb begin
    cpu_dout = 8'h00;
    if (cpu_sel && cpu_rw) begin
      case (cpu_addr)
        fdc_pkg::ADDR_CMD:    cpu_dout = fdc_status;
        fdc_pkg::ADDR_TRACK:  cpu_dout = track;
        fdc_pkg::ADDR_SECTOR: cpu_dout = sector;
        fdc_pkg::ADDR_DATA:   cpu_dout = data;
        default:              cpu_dout = 8'h00;
      endcase
    end
  end

  // io processor view
  always_comb begin
    case (status_sel)
      fdc_pkg::IO_CMD:    status_byte = cmd;
      fdc_pkg::IO_TRACK:  status_byte = track;
      fdc_pkg::IO_SECTOR: status_byte = sector;
      fdc_pkg::IO_DATA:   status_byte = data;
      fdc_pkg::IO_DRIVE:  status_byte = {4'b0000, drv_sel, drv_side,
                                         state == fdc_pkg::ST_IO_WAIT};
      default:            status_byte = 8'h00;
    endcase
  end

  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start) begin
      cmd          <= 8'h00;
      track        <= 8'h00;
      sector       <= 8'h00;
      data         <= 8'h00;
      state        <= fdc_pkg::ST_IDLE;
      irq          <= 1'b0;
      step_dir     <= 1'b0;
      delay        <= '0;
      spin_request <= '0;
    end else begin
      spin_request <= '0;  // single-cycle strobe

      // io processor done with the transfer
      if (dma_ack && (state == fdc_pkg::ST_IO_WAIT)) begin
        state <= fdc_pkg::ST_IRQ_PENDING;
      end

      if (state == fdc_pkg::ST_INT_WAIT) begin
        if (delay != '0) begin
          delay <= delay - 1'b1;
        end else begin
          state <= fdc_pkg::ST_IRQ_PENDING;
        end
      end

      // end of busy phase, irq and !busy together
      if (state == fdc_pkg::ST_IRQ_PENDING) begin
        irq   <= 1'b1;
        state <= fdc_pkg::ST_IDLE;
      end

      // any access to address 0 acknowledges irq
      if (cpu_sel && (cpu_addr == fdc_pkg::ADDR_CMD)) begin
        irq <= 1'b0;
      end

      if (cpu_wr) begin
        case (cpu_addr)
          fdc_pkg::ADDR_CMD: begin
            cmd   <= cpu_din;
            state <= fdc_pkg::ST_INT_WAIT;  // default, zero delay
            delay <= '0;
            if (starts_motor) begin
              spin_request <= req_onehot;
            end

            if (cpu_din[7:4] == fdc_pkg::CMD_RESTORE) begin
              track <= 8'd0;
              delay <= DLY_W'(SEEK_DELAY);
            end else if (cpu_din[7:4] == fdc_pkg::CMD_SEEK) begin
              track <= data;  // target track sits in data reg
              delay <= DLY_W'(SEEK_DELAY);
            end else if (cpu_din[7:5] == fdc_pkg::CMD_STEP) begin
              delay <= DLY_W'(STEP_DELAY);
              if (cpu_din[4]) begin  // update flag
                track <= step_dir ? (track + 8'd1) : (track - 8'd1);
              end
            end else if (cpu_din[7:5] == fdc_pkg::CMD_STEP_IN) begin
              delay    <= DLY_W'(STEP_DELAY);
              step_dir <= 1'b1;
              if (cpu_din[4]) begin
                track <= track + 8'd1;
              end
            end else if (cpu_din[7:5] == fdc_pkg::CMD_STEP_OUT) begin
              delay    <= DLY_W'(STEP_DELAY);
              step_dir <= 1'b0;
              if (cpu_din[4]) begin
                track <= track - 8'd1;
              end
            end else if (cpu_din[7:5] == fdc_pkg::CMD_RD_SECTOR) begin
              state <= fdc_pkg::ST_IO_WAIT;
            end else if (cpu_din[7:5] == fdc_pkg::CMD_WR_SECTOR) begin
              if (!sel_status.wr_prot) begin  // protected: quick int_wait, irq
                state <= fdc_pkg::ST_IO_WAIT;
              end
            end else if (cpu_din[7:4] == fdc_pkg::CMD_FORCE_INT) begin
              if (cpu_din[3:0] == 4'b0000) begin
                state <= fdc_pkg::ST_IDLE;         // silent abort
              end else begin
                state <= fdc_pkg::ST_IRQ_PENDING;  // abort with irq
              end
            end else if (cpu_din[7:4] == fdc_pkg::CMD_WR_TRACK) begin
              if (!sel_status.wr_prot) begin
                state <= fdc_pkg::ST_IO_WAIT;
              end
            end else begin
              state <= fdc_pkg::ST_IO_WAIT;  // read address, read track
            end
          end
          fdc_pkg::ADDR_TRACK:  track  <= cpu_din;
          fdc_pkg::ADDR_SECTOR: sector <= cpu_din;
          fdc_pkg::ADDR_DATA:   data   <= cpu_din;
          default:              data   <= data;
        endcase
      end
    end
  end

  // motor request never reaches two drives at once
  a_spin_onehot: assert property (@(posedge clk) disable iff (motor_start)
    $onehot0(spin_request));

  // irq only once a command has left the dma wait
  a_irq_not_io_wait: assert property (@(posedge clk) disable iff (motor_start)
    !(irq && (state == fdc_pkg::ST_IO_WAIT)));

endmodule

//--- hdl/floppy_drive.sv
// floppy drive model: motor run timer with spin-up, index pulse and write protect
`timescale 1ns/10ps

module floppy_drive #(
  parameter int MOTOR_RUN    = 16000000,
  parameter int SPINUP       = 8000000,
  parameter int INDEX_PERIOD = 1600000,
  parameter int INDEX_WIDTH  = 100000
) (
  input  logic                   clk,
  input  logic                   motor_start,   // async reset
  input  logic                   spin_request,  // one-cycle start/retrigger
  input  logic                   wr_prot,
  output fdc_pkg::drive_status_t status
);

  localparam int MOTOR_MAX = MOTOR_RUN + SPINUP;
  localparam int MOTOR_W   = (MOTOR_MAX < 2) ? 1 : $clog2(MOTOR_MAX + 1);
  localparam int ROT_W     = (INDEX_PERIOD < 2) ? 1 : $clog2(INDEX_PERIOD);

  logic [MOTOR_W-1:0] motor_cnt;  // cycles left until the motor stops
  logic [ROT_W-1:0]   rot_cnt;    // position within one rotation, counts down
  logic               motor_on;
  logic               spun_up;
  logic               motor_stopping;
  logic               index;

  assign motor_on = (motor_cnt != '0);
  assign spun_up  = motor_on && (motor_cnt <= MOTOR_W'(MOTOR_RUN));  // above run = spin-up

  // last running cycle, rotation is parked with the motor
  assign motor_stopping = (motor_cnt == MOTOR_W'(1)) && !spin_request;

  // motor timer
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start) begin
      motor_cnt <= '0;
    end else if (spin_request) begin
      // already spinning: just extend, from rest: add spin-up time
      motor_cnt <= motor_on ? MOTOR_W'(MOTOR_RUN) : MOTOR_W'(MOTOR_MAX);
    end else if (motor_on) begin
      motor_cnt <= motor_cnt - 1'b1;
    end
  end

  // rotation counter, held at 0 with motor off
  always_ff @(posedge clk or posedge motor_start) begin
    if (motor_start) begin
      rot_cnt <= '0;
    end else if (!motor_on || motor_stopping) begin
      rot_cnt <= '0;
    end else if (rot_cnt == '0) begin
      rot_cnt <= ROT_W'(INDEX_PERIOD - 1);  // new revolution
    end else begin
      rot_cnt <= rot_cnt - 1'b1;
    end
  end

  // top INDEX_WIDTH counts = start of each revolution
  assign index = (rot_cnt != '0) && (rot_cnt >= ROT_W'(INDEX_PERIOD - INDEX_WIDTH));

  assign status = '{
    motor_on: motor_on,
    spun_up:  spun_up,
    index:    index,
    wr_prot:  wr_prot
  };

  // rotation parks in step with the motor timer
  a_index_needs_motor: assert property (@(posedge clk) disable iff (motor_start)
    status.index |-> status.motor_on);

endmodule

//--- hdl/drive_select.sv
// drive selector: routes the selected drive's status back and ors the motor leds
`timescale 1ns/10ps

module drive_select #(
  parameter int NUM_DRIVES = 2
) (
  input  logic                   [1:0] drv_sel,
  input  fdc_pkg::drive_status_t       drive_status [NUM_DRIVES],
  output fdc_pkg::drive_status_t       sel_status,
  output logic                         any_motor_on  // front panel led
);

  logic [NUM_DRIVES-1:0] sel_vec;  // select lines per drive

  // drives past the two select lines stay unselected
  for (genvar g = 0; g < NUM_DRIVES; g++) begin : g_sel
    if (g < 2) begin : g_line
      assign sel_vec[g] = drv_sel[g];
    end else begin : g_none
      assign sel_vec[g] = 1'b0;
    end
  end

  // walk downwards so the lowest selected drive wins
  always_comb begin
    sel_status = '0;  // nothing selected: no motor, no protection
    for (int i = NUM_DRIVES - 1; i >= 0; i--) begin
      if (sel_vec[i]) begin
        sel_status = drive_status[i];
      end
    end
  end

  // led follows any running motor, selected or not
  always_comb begin
    any_motor_on = 1'b0;
    for (int i = 0; i < NUM_DRIVES; i++) begin
      any_motor_on = any_motor_on | drive_status[i].motor_on;
    end
  end

endmodule

//--- hdl/fdc_top.sv
// fdc top level: register block, array of drive models and drive selector
`timescale 1ns/10ps

module fdc_top #(
  parameter int NUM_DRIVES   = 2,
  parameter int SEEK_DELAY   = 200000,    // restore/seek, 25 ms at 8 MHz
  parameter int STEP_DELAY   = 20000,     // 2.5 ms
  parameter int MOTOR_RUN    = 16000000,  // 2 s
  parameter int SPINUP       = 8000000,   // extra 1 s from rest
  parameter int INDEX_PERIOD = 1600000,   // 300 rpm
  parameter int INDEX_WIDTH  = 100000     // 1/16 rotation
) (
  input  logic                           clk,
  input  logic                           motor_start,  // async reset
  input  logic                           cpu_sel,
  input  logic                           cpu_rw,
  input  fdc_pkg::reg_addr_e             cpu_addr,
  input  logic                     [7:0] cpu_din,
  output logic                     [7:0] cpu_dout,
  input  logic                     [1:0] drv_sel,
  input  logic                           drv_side,
  input  logic          [NUM_DRIVES-1:0] wr_prot,      // one tab per drive
  input  logic                           dma_ack,
  input  fdc_pkg::io_status_sel_e        status_sel,
  output logic                     [7:0] status_byte,
  output logic                           irq,
  output logic                           any_motor_on
);

  logic [NUM_DRIVES-1:0]  spin_request;
  fdc_pkg::drive_status_t drive_status [NUM_DRIVES];
  fdc_pkg::drive_status_t sel_status;

  fdc_regs #(
    .NUM_DRIVES (NUM_DRIVES),
    .SEEK_DELAY (SEEK_DELAY),
    .STEP_DELAY (STEP_DELAY)
  ) u_fdc_regs (
    .clk          (clk),
    .motor_start  (motor_start),
    .cpu_sel      (cpu_sel),
    .cpu_rw       (cpu_rw),
    .cpu_addr     (cpu_addr),
    .cpu_din      (cpu_din),
    .cpu_dout     (cpu_dout),
    .irq          (irq),
    .drv_sel      (drv_sel),
    .drv_side     (drv_side),
    .dma_ack      (dma_ack),
    .status_sel   (status_sel),
    .status_byte  (status_byte),
    .sel_status   (sel_status),
    .spin_request (spin_request)
  );

  // one mechanism per drive
  for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_drive
    floppy_drive #(
      .MOTOR_RUN    (MOTOR_RUN),
      .SPINUP       (SPINUP),
      .INDEX_PERIOD (INDEX_PERIOD),
      .INDEX_WIDTH  (INDEX_WIDTH)
    ) u_floppy_drive (
      .clk          (clk),
      .motor_start  (motor_start),
      .spin_request (spin_request[i]),
      .wr_prot      (wr_prot[i]),
      .status       (drive_status[i])
    );
  end

  drive_select #(
    .NUM_DRIVES (NUM_DRIVES)
  ) u_drive_select (
    .drv_sel      (drv_sel),
    .drive_status (drive_status),
    .sel_status   (sel_status),
    .any_motor_on (any_motor_on)
  );

endmodule

//--- testbench/tb_fdc.sv
// fdc testbench checking register access, command timing, drive status and drive selection
`timescale 1ns/10ps

module tb_fdc;

  localparam int NUM_DRIVES   = 2;
  localparam int SEEK_DELAY   = 12;
  localparam int STEP_DELAY   = 5;
  localparam int MOTOR_RUN    = 60;
  localparam int SPINUP       = 30;
  localparam int INDEX_PERIOD = 16;
  localparam int INDEX_WIDTH  = 3;
  localparam int IRQ_LIMIT    = 4 * SEEK_DELAY + 20;  // cycles
  localparam int WATCHDOG     = 20000;

  // one command per row with the io_wait level expected right after issue
  typedef struct packed {
    logic [7:0] cmd;
    logic [1:0] sel;
    logic [1:0] prot;
    logic       exp_wait;
  } step_t;

  logic                    clk;
  logic                    motor_start;
  logic                    cpu_sel;
  logic                    cpu_rw;
  fdc_pkg::reg_addr_e      cpu_addr;
  logic [7:0]              cpu_din;
  logic [7:0]              cpu_dout;
  logic [1:0]              drv_sel;
  logic                    drv_side;
  logic [NUM_DRIVES-1:0]   wr_prot;
  logic                    dma_ack;
  fdc_pkg::io_status_sel_e status_sel;
  logic [7:0]              status_byte;
  logic                    irq;
  logic                    any_motor_on;

  int         n_checks;
  int         n_value_err;
  int         n_timeout;
  logic [7:0] model_track;  // reference track register
  logic [7:0] model_data;
  logic       model_dir;    // 1 = stepping in

  step_t stim [16] = '{
    '{8'h00, 2'b01, 2'b00, 1'b0},  // restore
    '{8'h10, 2'b01, 2'b00, 1'b0},  // seek to data
    '{8'h50, 2'b01, 2'b00, 1'b0},  // step-in with update
    '{8'h40, 2'b01, 2'b00, 1'b0},  // step-in without update
    '{8'h30, 2'b01, 2'b00, 1'b0},  // step keeps direction in
    '{8'h70, 2'b01, 2'b00, 1'b0},  // step-out with update
    '{8'h30, 2'b01, 2'b00, 1'b0},  // step now outwards
    '{8'h20, 2'b01, 2'b00, 1'b0},  // step without update
    '{8'h80, 2'b01, 2'b00, 1'b1},  // read sector
    '{8'hA0, 2'b01, 2'b10, 1'b1},  // write sector with the other drive protected
    '{8'hA0, 2'b01, 2'b01, 1'b0},  // write sector to a protected drive
    '{8'hC0, 2'b01, 2'b00, 1'b1},  // read address
    '{8'hF0, 2'b01, 2'b01, 1'b0},  // write track to a protected drive
    '{8'hE0, 2'b01, 2'b00, 1'b1},  // read track
    '{8'h10, 2'b10, 2'b00, 1'b0},  // seek on drive 1
    '{8'h00, 2'b10, 2'b00, 1'b0}
  };

  fdc_top #(
    .NUM_DRIVES   (NUM_DRIVES),
    .SEEK_DELAY   (SEEK_DELAY),
    .STEP_DELAY   (STEP_DELAY),
    .MOTOR_RUN    (MOTOR_RUN),
    .SPINUP       (SPINUP),
    .INDEX_PERIOD (INDEX_PERIOD),
    .INDEX_WIDTH  (INDEX_WIDTH)
  ) u_fdc_top (
    .clk          (clk),
    .motor_start  (motor_start),
    .cpu_sel      (cpu_sel),
    .cpu_rw       (cpu_rw),
    .cpu_addr     (cpu_addr),
    .cpu_din      (cpu_din),
    .cpu_dout     (cpu_dout),
    .drv_sel      (drv_sel),
    .drv_side     (drv_side),
    .wr_prot      (wr_prot),
    .dma_ack      (dma_ack),
    .status_sel   (status_sel),
    .status_byte  (status_byte),
    .irq          (irq),
    .any_motor_on (any_motor_on)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  // hard stop if a bounded wait is ever bypassed
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_value_err++;
      $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input fdc_pkg::drive_status_t got,
                              input fdc_pkg::drive_status_t exp);
    n_checks++;
    if (got !== exp) begin
      n_value_err++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_value_err++;
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    n_timeout++;
    $display("timeout: %s", what);
  endtask

  // type I layout of the cpu status register
  function automatic fdc_pkg::drive_status_t status_fields(input logic [7:0] b);
    fdc_pkg::drive_status_t s;
    s.motor_on = b[7];
    s.wr_prot  = b[6];
    s.spun_up  = b[5];
    s.index    = b[1];
    return s;
  endfunction

  task automatic write_reg(input fdc_pkg::reg_addr_e a, input logic [7:0] v);
    @(negedge clk);
    cpu_sel  = 1'b1;
    cpu_rw   = 1'b0;
    cpu_addr = a;
    cpu_din  = v;
    @(negedge clk);
    cpu_sel = 1'b0;
    cpu_rw  = 1'b1;
    if (a == fdc_pkg::ADDR_TRACK) model_track = v;
    if (a == fdc_pkg::ADDR_DATA) model_data = v;
  endtask

  task automatic read_reg(input fdc_pkg::reg_addr_e a, output logic [7:0] v);
    @(negedge clk);
    cpu_sel  = 1'b1;
    cpu_rw   = 1'b1;
    cpu_addr = a;
    #2 v = cpu_dout;  // combinational read
    @(negedge clk);
    cpu_sel = 1'b0;
  endtask

  // command write with an optional busy read in the following cycle
  task automatic issue_cmd(input logic [7:0] c, input logic chk_busy);
    @(negedge clk);
    cpu_sel  = 1'b1;
    cpu_rw   = 1'b0;
    cpu_addr = fdc_pkg::ADDR_CMD;
    cpu_din  = c;
    @(negedge clk);
    if (chk_busy) begin
      cpu_rw = 1'b1;
      #2 check_flag("busy", cpu_dout[0], 1'b1);
      @(negedge clk);
    end
    cpu_sel = 1'b0;
    cpu_rw  = 1'b1;
  endtask

  // track and direction as the type I rules move them
  task automatic model_cmd(input logic [7:0] c);
    if (c[7:4] == 4'b0000) begin
      model_track = 8'd0;
    end else if (c[7:4] == 4'b0001) begin
      model_track = model_data;
    end else if (c[7:5] == 3'b001) begin
      if (c[4]) model_track = model_dir ? model_track + 8'd1 : model_track - 8'd1;
    end else if (c[7:5] == 3'b010) begin
      model_dir = 1'b1;
      if (c[4]) model_track = model_track + 8'd1;
    end else if (c[7:5] == 3'b011) begin
      model_dir = 1'b0;
      if (c[4]) model_track = model_track - 8'd1;
    end
  endtask

  task automatic wait_irq(input string what);
    int n;
    n = 0;
    while (!irq && n < IRQ_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!irq) report_timeout($sformatf("irq never rose after %s", what));
  endtask

  task automatic run_step(input step_t s, input int idx);
    logic [7:0] b;
    if (s.cmd[7:4] == 4'b0001) write_reg(fdc_pkg::ADDR_DATA, 8'($urandom));  // seek target
    @(negedge clk);
    drv_sel    = s.sel;
    wr_prot    = s.prot;
    drv_side   = idx[0];
    status_sel = fdc_pkg::IO_DRIVE;
    issue_cmd(s.cmd, 1'b1);
    model_cmd(s.cmd);
    #2 check_byte("status_byte", status_byte, {4'b0000, s.sel, drv_side, s.exp_wait});
    if (s.exp_wait) begin
      repeat (3) @(negedge clk);
      #2 check_flag("io_wait", status_byte[0], 1'b1);  // still held without an ack
      check_flag("irq", irq, 1'b0);
      @(negedge clk);
      dma_ack = 1'b1;
      @(negedge clk);
      dma_ack = 1'b0;
    end
    wait_irq($sformatf("command 0x%02h", s.cmd));
    check_flag("io_wait", status_byte[0], 1'b0);
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("busy", b[0], 1'b0);
    check_flag("irq", irq, 1'b0);  // status read acknowledged it
    read_reg(fdc_pkg::ADDR_TRACK, b);
    check_byte("track", b, model_track);
    @(negedge clk);
    status_sel = fdc_pkg::IO_CMD;
    #2 check_byte("status_byte", status_byte, s.cmd);
  endtask

  initial begin
    logic [7:0] b;
    logic [7:0] v;
    int         n;
    motor_start = 1'b1;
    cpu_sel     = 1'b0;
    cpu_rw      = 1'b1;
    cpu_addr    = fdc_pkg::ADDR_CMD;
    cpu_din     = 8'h00;
    drv_sel     = 2'b00;
    drv_side    = 1'b0;
    wr_prot     = '0;
    dma_ack     = 1'b0;
    status_sel  = fdc_pkg::IO_CMD;
    n_checks    = 0;
    n_value_err = 0;
    n_timeout   = 0;
    model_track = 8'h00;
    model_data  = 8'h00;
    model_dir   = 1'b0;
    void'($urandom(32'h8ce5));
    repeat (8) @(posedge clk);
    @(negedge clk);
    motor_start = 1'b0;

    // register readback on both ports
    for (int r = 0; r < 4; r++) begin
      for (int a = 1; a < 4; a++) begin
        v = 8'($urandom);
        write_reg(fdc_pkg::reg_addr_e'(a), v);
        read_reg(fdc_pkg::reg_addr_e'(a), b);
        check_byte("cpu_dout", b, v);
        @(negedge clk);
        status_sel = fdc_pkg::io_status_sel_e'(a);  // codes match addresses
        #2 check_byte("status_byte", status_byte, v);
      end
    end
    @(negedge clk);
    cpu_addr = fdc_pkg::ADDR_DATA;
    #2 check_byte("cpu_dout", cpu_dout, 8'h00);  // deselected

    // motor from rest through spin-up, index and run-out
    @(negedge clk);
    drv_sel = 2'b01;
    issue_cmd(8'h00, 1'b0);
    model_cmd(8'h00);
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_status("drive status", status_fields(b), fdc_pkg::drive_status_t'(4'b1000));
    check_flag("any_motor_on", any_motor_on, 1'b1);
    n = 0;
    while (!b[5] && n < SPINUP) begin
      read_reg(fdc_pkg::ADDR_CMD, b);
      n++;
    end
    if (!b[5]) report_timeout("drive never reported spun_up");
    n = 0;
    b = 8'h00;
    while (!b[1] && n < INDEX_PERIOD / 2 + 1) begin  // two cycles per read
      read_reg(fdc_pkg::ADDR_CMD, b);
      n++;
    end
    if (!b[1]) report_timeout("no index pulse within one rotation");
    check_flag("motor_on", b[7], 1'b1);
    n = 0;
    while (any_motor_on && n < MOTOR_RUN + SPINUP + 4) begin
      @(negedge clk);
      n++;
    end
    if (any_motor_on) report_timeout("motor never stopped");
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_status("drive status", status_fields(b), fdc_pkg::drive_status_t'(4'b0000));

    for (int i = 0; i < 16; i++) begin
      run_step(stim[i], i);
    end

    // silent abort during io_wait and then an abort with irq
    @(negedge clk);
    drv_sel    = 2'b01;
    wr_prot    = '0;
    status_sel = fdc_pkg::IO_DRIVE;
    issue_cmd(8'h80, 1'b1);
    #2 check_flag("io_wait", status_byte[0], 1'b1);
    issue_cmd(8'hD0, 1'b0);
    repeat (4) @(negedge clk);
    #2 check_flag("irq", irq, 1'b0);
    check_flag("io_wait", status_byte[0], 1'b0);
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("busy", b[0], 1'b0);
    issue_cmd(8'hD8, 1'b0);
    wait_irq("force interrupt 0xd8");
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("busy", b[0], 1'b0);

    // selection routes each drive's own protect tab
    @(negedge clk);
    drv_sel = 2'b10;
    wr_prot = 2'b10;
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("wr_prot", b[6], 1'b1);
    @(negedge clk);
    drv_sel = 2'b01;
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("wr_prot", b[6], 1'b0);
    @(negedge clk);
    drv_sel = 2'b11;  // lowest drive wins
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_flag("wr_prot", b[6], 1'b0);
    @(negedge clk);
    drv_sel = 2'b00;
    wr_prot = 2'b11;
    read_reg(fdc_pkg::ADDR_CMD, b);
    check_status("drive status", status_fields(b), fdc_pkg::drive_status_t'(4'b0000));

    $display("checks: %0d, value errors: %0d, timeouts: %0d", n_checks, n_value_err, n_timeout);
    if (n_value_err == 0 && n_timeout == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
hdl/fdc_pkg.sv
hdl/fdc_regs.sv
hdl/floppy_drive.sv
hdl/drive_select.sv
hdl/fdc_top.sv
testbench/tb_fdc.sv

//--- run_sim.sh
#!/bin/sh
# build the fdc testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fdc -o sim_fdc
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_fdc)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
